// ==== core_cfg_pkg.sv ====
// core sizing constants
package core_cfg_pkg;

	// data and address width
	localparam int XLEN = 32;

	// register index width and count
	localparam int REG_AW   = 5;
	localparam int NUM_REGS = 32;

	// first fetch address after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

endpackage

// ==== cpu_top.sv ====
// single-cycle rv32i subset core
`timescale 1ns/1ps

module cpu_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [core_cfg_pkg::XLEN-1:0]   inst,
	output logic [core_cfg_pkg::XLEN-1:0]   pc,
	output logic                            halted,
	output logic                            mem_wen,
	output logic [core_cfg_pkg::XLEN-1:0]   mem_addr,
	output logic [core_cfg_pkg::XLEN-1:0]   mem_wdata,
	output logic                            wb_en,
	output logic [core_cfg_pkg::REG_AW-1:0] wb_addr,
	output logic [core_cfg_pkg::XLEN-1:0]   wb_data
);

	logic [core_cfg_pkg::XLEN-1:0]   next_pc;
	logic [core_cfg_pkg::XLEN-1:0]   src1;
	logic [core_cfg_pkg::XLEN-1:0]   src2;
	logic [core_cfg_pkg::XLEN-1:0]   store_data;
	logic [core_cfg_pkg::REG_AW-1:0] rd;
	logic                            is_jump;
	logic                            is_jalr;
	logic                            is_store;
	logic                            write_reg;
	logic                            is_ebreak;

	ifu i_ifu (
		.clk       (clk),
		.rst_n     (rst_n),
		.next_pc   (next_pc),
		.is_ebreak (is_ebreak),
		.pc        (pc),
		.halted    (halted)
	);

	// writeback bus loops back into the register file
	idu i_idu (
		.clk        (clk),
		.rst_n      (rst_n),
		.inst       (inst),
		.pc         (pc),
		.wb_en      (wb_en),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.src1       (src1),
		.src2       (src2),
		.store_data (store_data),
		.rd         (rd),
		.is_jump    (is_jump),
		.is_jalr    (is_jalr),
		.is_store   (is_store),
		.write_reg  (write_reg),
		.is_ebreak  (is_ebreak)
	);

	exu i_exu (
		.pc         (pc),
		.src1       (src1),
		.src2       (src2),
		.store_data (store_data),
		.rd         (rd),
		.is_jump    (is_jump),
		.is_jalr    (is_jalr),
		.is_store   (is_store),
		.write_reg  (write_reg),
		.halted     (halted),
		.next_pc    (next_pc),
		.wb_en      (wb_en),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.mem_wen    (mem_wen),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata)
	);

endmodule

// ==== exu.sv ====
// execute unit
`timescale 1ns/1ps

module exu (
	input  logic [core_cfg_pkg::XLEN-1:0]   pc,
	input  logic [core_cfg_pkg::XLEN-1:0]   src1,
	input  logic [core_cfg_pkg::XLEN-1:0]   src2,
	input  logic [core_cfg_pkg::XLEN-1:0]   store_data,
	input  logic [core_cfg_pkg::REG_AW-1:0] rd,
	input  logic                            is_jump,
	input  logic                            is_jalr,
	input  logic                            is_store,
	input  logic                            write_reg,
	input  logic                            halted,
	output logic [core_cfg_pkg::XLEN-1:0]   next_pc,
	output logic                            wb_en,
	output logic [core_cfg_pkg::REG_AW-1:0] wb_addr,
	output logic [core_cfg_pkg::XLEN-1:0]   wb_data,
	output logic                            mem_wen,
	output logic [core_cfg_pkg::XLEN-1:0]   mem_addr,
	output logic [core_cfg_pkg::XLEN-1:0]   mem_wdata
);

	logic [core_cfg_pkg::XLEN-1:0] sum;
	logic [core_cfg_pkg::XLEN-1:0] pc_plus4;
	logic [core_cfg_pkg::XLEN-1:0] jump_target;

	// the only ALU operation needed is add
	assign sum      = src1 + src2;
	assign pc_plus4 = pc + core_cfg_pkg::XLEN'(4);

	// jalr drops bit 0 of the computed target
	assign jump_target = is_jalr ? {sum[core_cfg_pkg::XLEN-1:1], 1'b0} : sum;

	always_comb begin
		if (is_jump) begin
			next_pc = jump_target;
			wb_data = pc_plus4;
		end else begin
			next_pc = pc_plus4;
			wb_data = sum;
		end
	end

	// nothing retires once halted
	assign wb_en   = write_reg & ~halted;
	assign wb_addr = rd;

	assign mem_wen   = is_store & ~halted;
	assign mem_addr  = sum;
	assign mem_wdata = store_data;

endmodule

// ==== files.f ====
rv_isa_pkg.sv
core_cfg_pkg.sv
regfile.sv
ifu.sv
idu.sv
exu.sv
cpu_top.sv
tb_cpu_top.sv

// ==== idu.sv ====
// instruction decode unit
`timescale 1ns/1ps

module idu (
	input  logic                            clk,
	input  logic                            rst_n,
	input  rv_isa_pkg::inst_t               inst,
	input  logic [core_cfg_pkg::XLEN-1:0]   pc,
	input  logic                            wb_en,
	input  logic [core_cfg_pkg::REG_AW-1:0] wb_addr,
	input  logic [core_cfg_pkg::XLEN-1:0]   wb_data,
	output logic [core_cfg_pkg::XLEN-1:0]   src1,
	output logic [core_cfg_pkg::XLEN-1:0]   src2,
	output logic [core_cfg_pkg::XLEN-1:0]   store_data,
	output logic [core_cfg_pkg::REG_AW-1:0] rd,
	output logic                            is_jump,
	output logic                            is_jalr,
	output logic                            is_store,
	output logic                            write_reg,
	output logic                            is_ebreak
);

	logic [core_cfg_pkg::XLEN-1:0] imm_i;
	logic [core_cfg_pkg::XLEN-1:0] imm_s;
	logic [core_cfg_pkg::XLEN-1:0] imm_u;
	logic [core_cfg_pkg::XLEN-1:0] imm_j;
	logic [core_cfg_pkg::XLEN-1:0] rs1_data;
	logic [core_cfg_pkg::XLEN-1:0] rs2_data;
	logic                          inst_addi;
	logic                          inst_auipc;
	logic                          inst_lui;
	logic                          inst_jal;
	logic                          inst_jalr;
	logic                          inst_sw;

	// opcode and funct3 sit in the same place in every view
	assign inst_addi  = (inst.i.opcode == rv_isa_pkg::OP_IMM) &&
		(inst.i.funct3 == rv_isa_pkg::F3_ADDI);
	assign inst_auipc = (inst.u.opcode == rv_isa_pkg::OP_AUIPC);
	assign inst_lui   = (inst.u.opcode == rv_isa_pkg::OP_LUI);
	assign inst_jal   = (inst.j.opcode == rv_isa_pkg::OP_JAL);
	assign inst_jalr  = (inst.i.opcode == rv_isa_pkg::OP_JALR) &&
		(inst.i.funct3 == rv_isa_pkg::F3_JALR);
	assign inst_sw    = (inst.s.opcode == rv_isa_pkg::OP_STORE) &&
		(inst.s.funct3 == rv_isa_pkg::F3_SW);
	assign is_ebreak  = (inst == rv_isa_pkg::EBREAK_WORD);

	// sign-extended immediates
	assign imm_i = {{(core_cfg_pkg::XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
	assign imm_s = {{(core_cfg_pkg::XLEN-12){inst.s.imm_11_5[6]}},
		inst.s.imm_11_5, inst.s.imm_4_0};
	assign imm_u = {inst.u.imm_31_12, 12'b0};
	assign imm_j = {{(core_cfg_pkg::XLEN-21){inst.j.imm_20}}, inst.j.imm_20,
		inst.j.imm_19_12, inst.j.imm_11, inst.j.imm_10_1, 1'b0};

	regfile i_regfile (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr1 (inst.r.rs1),
		.raddr2 (inst.r.rs2),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data),
		.wen    (wb_en),
		.waddr  (wb_addr),
		.wdata  (wb_data)
	);

	// first operand, lui adds its immediate to zero
	always_comb begin
		if (inst_jal || inst_auipc) begin
			src1 = pc;
		end else if (inst_lui) begin
			src1 = '0;
		end else begin
			src1 = rs1_data;
		end
	end

	// second operand is always an immediate in this subset
	always_comb begin
		src2 = '0;
		if (inst_addi || inst_jalr) begin
			src2 = imm_i;
		end else if (inst_lui || inst_auipc) begin
			src2 = imm_u;
		end else if (inst_jal) begin
			src2 = imm_j;
		end else if (inst_sw) begin
			src2 = imm_s;
		end
	end

	assign store_data = rs2_data;
	assign rd         = inst.r.rd;
	assign is_jump    = inst_jal | inst_jalr;
	assign is_jalr    = inst_jalr;
	assign is_store   = inst_sw;
	assign write_reg  = inst_lui | inst_auipc | inst_addi | inst_jal | inst_jalr;

endmodule

// ==== ifu.sv ====
// instruction fetch unit
`timescale 1ns/1ps

module ifu (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [core_cfg_pkg::XLEN-1:0] next_pc,
	input  logic                          is_ebreak,
	output logic [core_cfg_pkg::XLEN-1:0] pc,
	output logic                          halted
);

	logic pc_hold;

	// pc stays on the ebreak and on everything after it
	assign pc_hold = halted | is_ebreak;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= core_cfg_pkg::RESET_PC;
		end else if (!pc_hold) begin
			pc <= next_pc;
		end
	end

	// sticky until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halted <= 1'b0;
		end else if (is_ebreak) begin
			halted <= 1'b1;
		end
	end

endmodule

// ==== regfile.sv ====
// integer register file
`timescale 1ns/1ps

module regfile (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [core_cfg_pkg::REG_AW-1:0] raddr1,
	input  logic [core_cfg_pkg::REG_AW-1:0] raddr2,
	output logic [core_cfg_pkg::XLEN-1:0]   rdata1,
	output logic [core_cfg_pkg::XLEN-1:0]   rdata2,
	input  logic                            wen,
	input  logic [core_cfg_pkg::REG_AW-1:0] waddr,
	input  logic [core_cfg_pkg::XLEN-1:0]   wdata
);

	// x0 has no storage
	logic [core_cfg_pkg::XLEN-1:0] regs [1:core_cfg_pkg::NUM_REGS-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 1; k < core_cfg_pkg::NUM_REGS; k++) begin
				regs[k] <= '0;
			end
		end else if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// asynchronous reads, x0 reads back zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== rv_isa_pkg.sv ====
// rv32i instruction encodings
package rv_isa_pkg;

	// major opcodes, bits [6:0]
	localparam logic [6:0] OP_IMM    = 7'b001_0011;
	localparam logic [6:0] OP_AUIPC  = 7'b001_0111;
	localparam logic [6:0] OP_LUI    = 7'b011_0111;
	localparam logic [6:0] OP_JAL    = 7'b110_1111;
	localparam logic [6:0] OP_JALR   = 7'b110_0111;
	localparam logic [6:0] OP_STORE  = 7'b010_0011;
	localparam logic [6:0] OP_SYSTEM = 7'b111_0011;

	// funct3 values of the supported subset
	localparam logic [2:0] F3_ADDI = 3'b000;
	localparam logic [2:0] F3_JALR = 3'b000;
	localparam logic [2:0] F3_SW   = 3'b010;

	// ebreak is matched on the whole word
	localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// jal offset is scrambled across the upper bits
	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		u_fmt_t u;
		j_fmt_t j;
	} inst_t;

endpackage

// ==== tb_cpu_top.sv ====
// cpu_top testbench
`timescale 1ns/1ps

module tb_cpu_top;

	localparam int NUM_STEPS   = 15;
	localparam int RESET_CYCLES = 5;
	localparam int CYCLE_LIMIT = RESET_CYCLES + 2 * NUM_STEPS + 20;
	localparam logic [core_cfg_pkg::XLEN-1:0] PC0 = core_cfg_pkg::RESET_PC;

	typedef struct packed {
		logic [core_cfg_pkg::XLEN-1:0]   inst;
		logic [core_cfg_pkg::XLEN-1:0]   pc;
		logic                            wb_en;
		logic [core_cfg_pkg::REG_AW-1:0] wb_addr;
		logic [core_cfg_pkg::XLEN-1:0]   wb_data;
		logic                            mem_wen;
		logic [core_cfg_pkg::XLEN-1:0]   mem_addr;
		logic [core_cfg_pkg::XLEN-1:0]   mem_wdata;
		logic                            halted;
	} step_t;

	logic                            clk;
	logic                            rst_n;
	logic [core_cfg_pkg::XLEN-1:0]   inst;
	logic [core_cfg_pkg::XLEN-1:0]   pc;
	logic                            halted;
	logic                            mem_wen;
	logic [core_cfg_pkg::XLEN-1:0]   mem_addr;
	logic [core_cfg_pkg::XLEN-1:0]   mem_wdata;
	logic                            wb_en;
	logic [core_cfg_pkg::REG_AW-1:0] wb_addr;
	logic [core_cfg_pkg::XLEN-1:0]   wb_data;

	step_t steps [NUM_STEPS];
	int    n_steps;
	int    step_idx;
	int    error_count;
	int    cycle_count;

	cpu_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.inst      (inst),
		.pc        (pc),
		.halted    (halted),
		.mem_wen   (mem_wen),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.wb_en     (wb_en),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// run limit, in clock cycles
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("simulation timed out after %0d cycles", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic add_step(input logic [31:0] inst_word, input logic [31:0] pc_val,
		input logic wen, input logic [4:0] waddr, input logic [31:0] wdata,
		input logic sen, input logic [31:0] saddr, input logic [31:0] sdata,
		input logic halt);
		steps[n_steps] = '{inst_word, pc_val, wen, waddr, wdata, sen, saddr, sdata, halt};
		n_steps++;
	endtask

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] step %0d %s: expected %h, got %h", step_idx, name,
				expected, actual);
			error_count++;
		end
	endtask

	task automatic load_program();
		// lui x1 then addi x1 with -16, then copy into x2
		add_step(32'h1234_50b7, PC0, 1'b1, 5'd1, 32'h1234_5000,
			1'b0, '0, '0, 1'b0);
		add_step(32'hff00_8093, PC0 + 32'h04, 1'b1, 5'd1, 32'h1234_5000 - 32'd16,
			1'b0, '0, '0, 1'b0);
		add_step(32'h0000_8113, PC0 + 32'h08, 1'b1, 5'd2, 32'h1234_4ff0,
			1'b0, '0, '0, 1'b0);
		// write to x0 is dropped, x3 = 0 + 7
		add_step(32'h0050_0013, PC0 + 32'h0c, 1'b1, 5'd0, 32'd5,
			1'b0, '0, '0, 1'b0);
		add_step(32'h0070_0193, PC0 + 32'h10, 1'b1, 5'd3, 32'd7,
			1'b0, '0, '0, 1'b0);
		// auipc x4, 0x1
		add_step(32'h0000_1217, PC0 + 32'h14, 1'b1, 5'd4, PC0 + 32'h14 + 32'h1000,
			1'b0, '0, '0, 1'b0);
		// jal x5, +16
		add_step(32'h0100_02ef, PC0 + 32'h18, 1'b1, 5'd5, PC0 + 32'h1c,
			1'b0, '0, '0, 1'b0);
		// jalr x6, 0x21(x4), odd sum
		add_step(32'h0212_0367, PC0 + 32'h28, 1'b1, 5'd6, PC0 + 32'h2c,
			1'b0, '0, '0, 1'b0);
		// sw x2, 8(x3) lands at the jalr target
		add_step(32'h0021_a423, (PC0 + 32'h1035) & ~32'h1, 1'b0, '0, '0,
			1'b1, 32'd7 + 32'd8, 32'h1234_4ff0, 1'b0);
		// add is not supported here
		add_step(32'h0020_81b3, PC0 + 32'h1038, 1'b0, '0, '0,
			1'b0, '0, '0, 1'b0);
		add_step(32'h0011_8393, PC0 + 32'h103c, 1'b1, 5'd7, 32'd8,
			1'b0, '0, '0, 1'b0);
		add_step(rv_isa_pkg::EBREAK_WORD, PC0 + 32'h1040, 1'b0, '0, '0,
			1'b0, '0, '0, 1'b0);
		// halted, pc frozen and nothing retires
		add_step(32'habcd_e437, PC0 + 32'h1040, 1'b0, '0, '0,
			1'b0, '0, '0, 1'b1);
		add_step(32'h0020_a023, PC0 + 32'h1040, 1'b0, '0, '0,
			1'b0, '0, '0, 1'b1);
		add_step(32'h0010_0493, PC0 + 32'h1040, 1'b0, '0, '0,
			1'b0, '0, '0, 1'b1);
	endtask

	initial begin
		rst_n = 1'b0;
		inst = '0;
		n_steps = 0;
		step_idx = 0;
		error_count = 0;
		cycle_count = 0;
		load_program();

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (step_idx = 0; step_idx < n_steps; step_idx++) begin
			inst = steps[step_idx].inst;
			// sample just ahead of the rising edge
			#4;
			check_equal("pc", steps[step_idx].pc, pc);
			check_equal("halted", 32'(steps[step_idx].halted), 32'(halted));
			check_equal("wb_en", 32'(steps[step_idx].wb_en), 32'(wb_en));
			check_equal("mem_wen", 32'(steps[step_idx].mem_wen), 32'(mem_wen));
			// commit payloads only matter when enabled
			if (steps[step_idx].wb_en) begin
				check_equal("wb_addr", 32'(steps[step_idx].wb_addr), 32'(wb_addr));
				check_equal("wb_data", steps[step_idx].wb_data, wb_data);
			end
			if (steps[step_idx].mem_wen) begin
				check_equal("mem_addr", steps[step_idx].mem_addr, mem_addr);
				check_equal("mem_wdata", steps[step_idx].mem_wdata, mem_wdata);
			end
			@(negedge clk);
		end

		$display("steps run: %0d, errors: %0d", n_steps, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
